// ==== verification/ptw_cases.txt ====
# m <pte address> <pte word>
# c <satp ppn> <vaddr> <instr> <store> <mxr> <flush cycle, 0 none> <outcome 0 fault 1 update 2 flushed> <leaf pte> <size 0 4K 1 2M 2 1G>
m 100008 40401
m 100010 40421
m 100018 10000043
m 100020 10080043
m 100028 40c01
m 100038 5
m 101010 40801
m 102018 48d14c7
m 102020 888849
m 102028 cccc47
m 102030 40801
m 103008 8004b
m 103010 8044b
c 100 40403000 0 0 0 0 1 48d14c7 0
c 100 40403000 0 1 0 0 1 48d14c7 0
c 100 40403000 1 0 0 0 0 0 0
c 100 c0a07000 0 0 0 0 1 10000043 2
c 100 100000000 0 0 0 0 0 0 0
c 100 140200000 0 0 0 0 1 8004b 1
c 100 140400000 0 0 0 0 0 0 0
c 100 180000000 0 0 0 0 0 0 0
c 100 1c0000000 0 0 0 0 0 0 0
c 100 40404000 0 0 0 0 0 0 0
c 100 40404000 0 0 1 0 1 888849 0
c 100 40405000 0 1 0 0 0 0 0
c 100 80403000 0 0 0 0 1 48d14e7 0
c 100 40406000 0 0 0 0 0 0 0
c 100 40403000 0 0 0 2 2 0 0
c 100 40403000 0 0 0 0 1 48d14c7 0
c 100 80403000 0 0 0 1 2 0 0
c 100 c0a07000 0 0 0 0 1 10000043 2

// ==== src.f ====
common/ptw_pkg.sv
common/walk_if.sv
walker/ptw_ctrl.sv
walker/pte_checker.sv
walker/walk_context.sv
rtl/ptw_top.sv
verification/tb_ptw.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the page table walker testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_ptw -f src.f --Mdir obj_dir -o tb_ptw

./obj_dir/tb_ptw | tee sim.log

if grep -qx "SIMULATION PASSED" sim.log; then
  echo "run passed, log in sim.log"
else
  echo "run did not pass, see sim.log"
  exit 1
fi

// ==== verification/tb_ptw.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_ptw;

  logic                       clk_i;
  logic                       rst_ni;
  logic                       flush_i;
  logic                       walk_req_i;
  logic                       walk_is_instr_i;
  logic                       walk_is_store_i;
  logic [ptw_pkg::vlen-1:0]   walk_vaddr_i;
  logic [ptw_pkg::asid_w-1:0] asid_i;
  logic [ptw_pkg::ppn_w-1:0]  satp_ppn_i;
  logic                       mxr_i;
  logic                       busy_o;
  logic                       mem_req_o;
  logic [ptw_pkg::plen-1:0]   mem_addr_o;
  logic                       mem_gnt_i;
  logic                       mem_rvalid_i;
  logic [ptw_pkg::pte_w-1:0]  mem_rdata_i;
  logic                       update_valid_o;
  logic [26:0]                update_vpn_o;
  logic [ptw_pkg::asid_w-1:0] update_asid_o;
  logic                       update_is_2m_o;
  logic                       update_is_1g_o;
  logic [ptw_pkg::pte_w-1:0]  update_pte_o;
  logic                       walk_error_o;

  // page table image, addresses not listed read as zero
  logic [63:0] mem_image [logic [55:0]];
  // nine fields per case, flattened
  logic [63:0] case_fields [$];
  int          n_cases;
  int          errors;
  bit          cases_loaded;

  // memory port state
  logic [55:0] gnt_addr;
  logic        gnt_q;
  int          gnt_wait;

  ptw_top dut0 (.*);

  always #50 clk_i = ~clk_i;

  function automatic logic [63:0] read_word(input logic [55:0] addr);
    if (mem_image.exists(addr)) begin
      return mem_image[addr];
    end else begin
      return 64'h0;
    end
  endfunction

  task automatic report_mismatch(input int idx, input string name,
                                 input logic [63:0] exp, input logic [63:0] act);
    errors = errors + 1;
    $display("FAILED case %0d %s expected %h actual %h", idx, name, exp, act);
  endtask

  task automatic report_reset_value(input string name, input logic act);
    errors = errors + 1;
    $display("FAILED after reset %s expected 0 actual %h", name, act);
  endtask

  // ---------------------------------------------------------------------------
  // case file
  // ---------------------------------------------------------------------------

  // line tags by first character, 35 '#', 109 'm', 99 'c', 10 newline
  task automatic load_cases(output bit ok);
    int          fd;
    int          ch;
    int          n;
    logic [63:0] addr;
    logic [63:0] data;
    logic [63:0] f [9];
    ok = 1'b1;
    fd = $fopen("verification/ptw_cases.txt", "r");
    if (fd == 0) begin
      $display("cannot open verification/ptw_cases.txt");
      ok = 1'b0;
    end else begin
      ch = $fgetc(fd);
      while (ch != -1) begin
        if (ch == 35) begin
          while (ch != 10 && ch != -1) begin
            ch = $fgetc(fd);
          end
        end else if (ch == 109) begin
          n = $fscanf(fd, "%h %h", addr, data);
          if (n != 2) begin
            $display("memory line %0d in the case file is malformed", mem_image.size());
            ok = 1'b0;
          end
          mem_image[addr[55:0]] = data;
        end else if (ch == 99) begin
          n = $fscanf(fd, "%h %h %h %h %h %h %h %h %h",
                      f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8]);
          if (n != 9) begin
            $display("case line %0d in the case file is malformed", n_cases);
            ok = 1'b0;
          end
          for (int k = 0; k < 9; k++) begin
            case_fields.push_back(f[k]);
          end
          n_cases = n_cases + 1;
        end
        ch = $fgetc(fd);
      end
      $fclose(fd);
    end
  endtask

  // ---------------------------------------------------------------------------
  // memory model
  // ---------------------------------------------------------------------------

  // grant after 0 to 3 cycles, rvalid in the cycle after the grant
  initial begin
    mem_gnt_i    = 1'b0;
    mem_rvalid_i = 1'b0;
    mem_rdata_i  = '0;
    gnt_q        = 1'b0;
    gnt_wait     = -1;
    gnt_addr     = '0;
    forever begin
      @(posedge clk_i);
      #1;
      mem_rvalid_i = gnt_q;
      if (gnt_q) begin
        mem_rdata_i = read_word(gnt_addr);
      end
      gnt_q = 1'b0;
      if (mem_req_o) begin
        if (gnt_wait < 0) begin
          gnt_wait = $urandom % 4;
        end
        if (gnt_wait == 0) begin
          gnt_q    = 1'b1;
          gnt_addr = mem_addr_o;
          gnt_wait = -1;
        end else begin
          gnt_wait = gnt_wait - 1;
        end
      end else begin
        // request withdrawn by a flush
        gnt_wait = -1;
      end
      mem_gnt_i = gnt_q;
    end
  end

  // ---------------------------------------------------------------------------
  // one walk
  // ---------------------------------------------------------------------------

  // outcome 0 fault, 1 update, 2 flushed; size 0 4K, 1 2M, 2 1G
  task automatic run_case(input int idx);
    logic [63:0] vaddr;
    logic [63:0] exp_pte;
    logic [15:0] asid;
    int          flush_at;
    int          outcome;
    int          size;
    int          since_gnt;
    int          n_upd;
    int          n_err;
    bit          done;
    logic [26:0] got_vpn;
    logic [15:0] got_asid;
    logic        got_2m;
    logic        got_1g;
    logic [63:0] got_pte;
    vaddr    = case_fields[idx*9+1];
    flush_at = int'(case_fields[idx*9+5]);
    outcome  = int'(case_fields[idx*9+6]);
    exp_pte  = case_fields[idx*9+7];
    size     = int'(case_fields[idx*9+8]);
    asid     = 16'($urandom);
    got_vpn  = '0;
    got_asid = '0;
    got_2m   = 1'b0;
    got_1g   = 1'b0;
    got_pte  = '0;

    @(posedge clk_i);
    #1;
    walk_req_i      = 1'b1;
    satp_ppn_i      = case_fields[idx*9][43:0];
    walk_vaddr_i    = vaddr[38:0];
    walk_is_instr_i = case_fields[idx*9+2][0];
    walk_is_store_i = case_fields[idx*9+3][0];
    mxr_i           = case_fields[idx*9+4][0];
    asid_i          = asid;
    @(posedge clk_i);
    #1;
    walk_req_i = 1'b0;

    // count pulses until busy drops
    // flush cycle counts from the first grant
    // so cycle 1 lands on a read still in flight
    since_gnt = -1;
    n_upd     = 0;
    n_err     = 0;
    done      = 1'b0;
    while (!done) begin
      flush_i = (flush_at != 0) && (since_gnt == flush_at);
      @(negedge clk_i);
      if (update_valid_o) begin
        n_upd    = n_upd + 1;
        got_vpn  = update_vpn_o;
        got_asid = update_asid_o;
        got_2m   = update_is_2m_o;
        got_1g   = update_is_1g_o;
        got_pte  = update_pte_o;
      end
      if (walk_error_o) begin
        n_err = n_err + 1;
      end
      if (!busy_o) begin
        done = 1'b1;
      end
      // grant taken at the coming edge
      if (since_gnt < 0 && mem_req_o && mem_gnt_i) begin
        since_gnt = 0;
      end
      @(posedge clk_i);
      #1;
      if (since_gnt >= 0) begin
        since_gnt = since_gnt + 1;
      end
    end
    flush_i = 1'b0;

    if (n_upd != ((outcome == 1) ? 1 : 0)) begin
      report_mismatch(idx, "update_valid_o pulses", 64'((outcome == 1) ? 1 : 0), 64'(n_upd));
    end
    if (n_err != ((outcome == 0) ? 1 : 0)) begin
      report_mismatch(idx, "walk_error_o pulses", 64'((outcome == 0) ? 1 : 0), 64'(n_err));
    end
    // tlb fields only mean something on a single update
    if (outcome == 1 && n_upd == 1) begin
      if (got_vpn != vaddr[38:12]) begin
        report_mismatch(idx, "update_vpn_o", 64'(vaddr[38:12]), 64'(got_vpn));
      end
      if (got_asid != asid) begin
        report_mismatch(idx, "update_asid_o", 64'(asid), 64'(got_asid));
      end
      if (got_1g != (size == 2)) begin
        report_mismatch(idx, "update_is_1g_o", 64'(size == 2), 64'(got_1g));
      end
      if (got_2m != (size == 1)) begin
        report_mismatch(idx, "update_is_2m_o", 64'(size == 1), 64'(got_2m));
      end
      if (got_pte[53:10] != exp_pte[53:10]) begin
        report_mismatch(idx, "update_pte_o ppn", 64'(exp_pte[53:10]), 64'(got_pte[53:10]));
      end
      if (got_pte != exp_pte) begin
        report_mismatch(idx, "update_pte_o", exp_pte, got_pte);
      end
    end
  endtask

  // ---------------------------------------------------------------------------
  // main and watchdog
  // ---------------------------------------------------------------------------

  initial begin
    int seed_ret;
    bit ok;
    clk_i           = 1'b0;
    rst_ni          = 1'b0;
    flush_i         = 1'b0;
    walk_req_i      = 1'b0;
    walk_is_instr_i = 1'b0;
    walk_is_store_i = 1'b0;
    walk_vaddr_i    = '0;
    asid_i          = '0;
    satp_ppn_i      = '0;
    mxr_i           = 1'b0;
    errors          = 0;
    n_cases         = 0;
    cases_loaded    = 1'b0;
    seed_ret        = $urandom(32'hef3dab5f);
    load_cases(ok);
    if (!ok) begin
      $display("case file missing or malformed, no walks were run");
      $display("SIMULATION FAILED");
      $finish;
    end else begin
      cases_loaded = 1'b1;
      repeat (8) @(posedge clk_i);
      #1;
      rst_ni = 1'b1;
      // walker idle and quiet out of reset
      @(negedge clk_i);
      if (busy_o !== 1'b0) begin
        report_reset_value("busy_o", busy_o);
      end
      if (mem_req_o !== 1'b0) begin
        report_reset_value("mem_req_o", mem_req_o);
      end
      if (update_valid_o !== 1'b0) begin
        report_reset_value("update_valid_o", update_valid_o);
      end
      if (walk_error_o !== 1'b0) begin
        report_reset_value("walk_error_o", walk_error_o);
      end
      for (int i = 0; i < n_cases; i++) begin
        run_case(i);
      end
      $display("walker checks done, %0d cases, %0d errors", n_cases, errors);
      if (errors == 0) begin
        $display("SIMULATION PASSED");
      end else begin
        $display("SIMULATION FAILED");
      end
      $finish;
    end
  end

  // 40 cycles per case plus reset
  initial begin
    wait (cases_loaded);
    repeat (n_cases * 40 + 8) @(posedge clk_i);
    $display("timeout, walks did not finish within %0d cycles", n_cases * 40 + 8);
    $display("SIMULATION FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// ==== rtl/ptw_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module ptw_top (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  input  logic                       flush_i,

  // walk request from the tlb miss path
  input  logic                       walk_req_i,
  input  logic                       walk_is_instr_i,
  input  logic                       walk_is_store_i,
  input  logic [ptw_pkg::vlen-1:0]   walk_vaddr_i,
  input  logic [ptw_pkg::asid_w-1:0] asid_i,
  input  logic [ptw_pkg::ppn_w-1:0]  satp_ppn_i,
  input  logic                       mxr_i,
  output logic                       busy_o,

  // single outstanding read port
  output logic                       mem_req_o,
  output logic [ptw_pkg::plen-1:0]   mem_addr_o,
  input  logic                       mem_gnt_i,
  input  logic                       mem_rvalid_i,
  input  logic [ptw_pkg::pte_w-1:0]  mem_rdata_i,

  // tlb update and fault
  output logic                       update_valid_o,
  output logic [26:0]                update_vpn_o,
  output logic [ptw_pkg::asid_w-1:0] update_asid_o,
  output logic                       update_is_2m_o,
  output logic                       update_is_1g_o,
  output logic [ptw_pkg::pte_w-1:0]  update_pte_o,
  output logic                       walk_error_o
);

  walk_if walk ();

  ptw_ctrl u_ctrl (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .flush_i         (flush_i),
    .walk_req_i      (walk_req_i),
    .walk_is_instr_i (walk_is_instr_i),
    .walk_is_store_i (walk_is_store_i),
    .mem_gnt_i       (mem_gnt_i),
    .mem_req_o       (mem_req_o),
    .busy_o          (busy_o),
    .update_valid_o  (update_valid_o),
    .walk_error_o    (walk_error_o),
    .walk            (walk.ctrl)
  );

  pte_checker u_checker (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .mem_rvalid_i (mem_rvalid_i),
    .mem_rdata_i  (mem_rdata_i),
    .mxr_i        (mxr_i),
    .walk         (walk.chk)
  );

  walk_context u_context (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .walk_vaddr_i   (walk_vaddr_i),
    .asid_i         (asid_i),
    .satp_ppn_i     (satp_ppn_i),
    .mem_addr_o     (mem_addr_o),
    .update_vpn_o   (update_vpn_o),
    .update_asid_o  (update_asid_o),
    .update_is_2m_o (update_is_2m_o),
    .update_is_1g_o (update_is_1g_o),
    .walk           (walk.ctx)
  );

  // entry with the global bit gathered over all levels
  assign update_pte_o = walk.leaf_pte;

endmodule

`default_nettype wire

// ==== walker/walk_context.sv ====
`timescale 1ns/1ps
`default_nettype none

module walk_context (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  input  logic [ptw_pkg::vlen-1:0]   walk_vaddr_i,
  input  logic [ptw_pkg::asid_w-1:0] asid_i,
  input  logic [ptw_pkg::ppn_w-1:0]  satp_ppn_i,
  output logic [ptw_pkg::plen-1:0]   mem_addr_o,
  output logic [26:0]                update_vpn_o,
  output logic [ptw_pkg::asid_w-1:0] update_asid_o,
  output logic                       update_is_2m_o,
  output logic                       update_is_1g_o,
  walk_if.ctx                        walk
);

  // vpn slice base positions inside the virtual address
  localparam int unsigned Vpn0Lsb = ptw_pkg::page_offset_w;
  localparam int unsigned Vpn1Lsb = ptw_pkg::page_offset_w + ptw_pkg::vpn_w;
  localparam int unsigned Vpn2Lsb = ptw_pkg::page_offset_w + 2 * ptw_pkg::vpn_w;

  logic [ptw_pkg::vlen-1:0]   vaddr_q;
  logic [ptw_pkg::asid_w-1:0] asid_q;
  logic [ptw_pkg::plen-1:0]   pptr_q;
  ptw_pkg::ptw_lvl_e          level_q;

  // next table index, vpn[1] below lvl1 and vpn[0] below lvl2
  logic [ptw_pkg::vpn_w-1:0]  next_vpn;

  assign next_vpn = (level_q == ptw_pkg::LVL1) ? vaddr_q[Vpn1Lsb +: ptw_pkg::vpn_w]
                                               : vaddr_q[Vpn0Lsb +: ptw_pkg::vpn_w];

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      level_q <= ptw_pkg::LVL1;
    end else if (walk.load) begin
      level_q <= ptw_pkg::LVL1;
    end else if (walk.advance) begin
      level_q <= (level_q == ptw_pkg::LVL1) ? ptw_pkg::LVL2 : ptw_pkg::LVL3;
    end
  end

  // pte address is table base plus index times entry size
  always_ff @(posedge clk_i) begin
    if (walk.load) begin
      vaddr_q <= walk_vaddr_i;
      asid_q  <= asid_i;
      pptr_q  <= {satp_ppn_i, walk_vaddr_i[Vpn2Lsb +: ptw_pkg::vpn_w],
                  {ptw_pkg::pte_size_log2{1'b0}}};
    end else if (walk.advance) begin
      pptr_q <= {walk.leaf_pte.ppn, next_vpn, {ptw_pkg::pte_size_log2{1'b0}}};
    end
  end

  assign walk.level = level_q;
  assign walk.pptr  = pptr_q;
  assign mem_addr_o = pptr_q;

  // tlb update fields
  assign update_vpn_o   = vaddr_q[ptw_pkg::vlen-1:ptw_pkg::page_offset_w];
  assign update_asid_o  = asid_q;
  assign update_is_1g_o = (level_q == ptw_pkg::LVL1);
  assign update_is_2m_o = (level_q == ptw_pkg::LVL2);

  // the checker turns an lvl3 pointer into a fault, never a step
  a_no_advance_lvl3: assert property (@(posedge clk_i) disable iff (!rst_ni)
    walk.advance |-> walk.level != ptw_pkg::LVL3)
    else $error("advance requested at the last level");

endmodule

`default_nettype wire

// ==== walker/pte_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

module pte_checker (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  logic                      mem_rvalid_i,
  input  logic [ptw_pkg::pte_w-1:0] mem_rdata_i,
  input  logic                      mxr_i,
  walk_if.chk                       walk
);

  // registered read response
  logic                rvalid_q;
  ptw_pkg::pte_word_u  rdata_q;
  ptw_pkg::pte_t       pte;

  // set once any level of this walk was global
  logic global_q;

  logic                  perm_ok;
  logic                  misaligned;
  ptw_pkg::pte_verdict_e verdict;
  ptw_pkg::pte_t         leaf_pte;

  assign pte = rdata_q.pte;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rvalid_q <= 1'b0;
      global_q <= 1'b0;
    end else begin
      rvalid_q <= mem_rvalid_i;
      if (walk.load) begin
        global_q <= 1'b0;
      end else if (rvalid_q && pte.g) begin
        global_q <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    rdata_q.raw <= mem_rdata_i;
  end

  // -------------------------------------------------------------------------
  // leaf checks
  // -------------------------------------------------------------------------

  // accessed and dirty are managed by software, so a clear bit faults
  always_comb begin
    if (walk.is_instr) begin
      perm_ok = pte.x && pte.a;
    end else begin
      // mxr lets loads read from execute only pages
      perm_ok = pte.a && (pte.r || (pte.x && mxr_i));
      if (walk.is_store && !(pte.w && pte.d)) begin
        perm_ok = 1'b0;
      end
    end
  end

  // superpage ppn must be aligned to its page size
  assign misaligned =
    (walk.level == ptw_pkg::LVL1 && pte.ppn[2*ptw_pkg::vpn_w-1:0] != '0) ||
    (walk.level == ptw_pkg::LVL2 && pte.ppn[ptw_pkg::vpn_w-1:0] != '0);

  // -------------------------------------------------------------------------
  // verdict
  // -------------------------------------------------------------------------

  always_comb begin
    verdict = ptw_pkg::NONE;
    if (rvalid_q) begin
      if (!pte.v || (!pte.r && pte.w)) begin
        // invalid, or the reserved write only encoding
        verdict = ptw_pkg::FAULT;
      end else if (!pte.r && !pte.x) begin
        // pointer, no table exists below lvl3
        verdict = (walk.level == ptw_pkg::LVL3) ? ptw_pkg::FAULT : ptw_pkg::POINTER;
      end else if (perm_ok && !misaligned) begin
        verdict = ptw_pkg::LEAF_OK;
      end else begin
        verdict = ptw_pkg::FAULT;
      end
    end
  end

  // current level's g bit joins the ones seen above it
  always_comb begin
    leaf_pte   = pte;
    leaf_pte.g = pte.g | global_q;
  end

  assign walk.verdict  = verdict;
  assign walk.leaf_pte = leaf_pte;

  // a verdict only ever follows a read response by one cycle
  a_verdict_after_rvalid: assert property (@(posedge clk_i) disable iff (!rst_ni)
    walk.verdict != ptw_pkg::NONE |-> $past(mem_rvalid_i))
    else $error("verdict without a registered read response");

endmodule

`default_nettype wire

// ==== walker/ptw_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module ptw_ctrl (
  input  logic   clk_i,
  input  logic   rst_ni,
  input  logic   flush_i,
  input  logic   walk_req_i,
  input  logic   walk_is_instr_i,
  input  logic   walk_is_store_i,
  input  logic   mem_gnt_i,
  output logic   mem_req_o,
  output logic   busy_o,
  output logic   update_valid_o,
  output logic   walk_error_o,
  walk_if.ctrl   walk
);

  typedef enum logic [2:0] {
    IDLE,
    WAIT_GRANT,
    PTE_LOOKUP,
    WAIT_RVALID,
    PROPAGATE_ERROR,
    LATENCY
  } state_e;

  state_e state_q, state_d;

  // access kind, held for the whole walk
  logic is_instr_q, is_instr_d;
  logic is_store_q, is_store_d;

  assign busy_o        = (state_q != IDLE);
  assign walk.is_instr = is_instr_q;
  assign walk.is_store = is_store_q;

  // -------------------------------------------------------------------------
  // walk sequencing
  // -------------------------------------------------------------------------

  always_comb begin
    state_d        = state_q;
    is_instr_d     = is_instr_q;
    is_store_d     = is_store_q;
    mem_req_o      = 1'b0;
    walk.load      = 1'b0;
    walk.advance   = 1'b0;
    update_valid_o = 1'b0;
    walk_error_o   = 1'b0;

    case (state_q)
      IDLE: begin
        // a flush in the same cycle drops the request
        if (walk_req_i && !flush_i) begin
          walk.load  = 1'b1;
          is_instr_d = walk_is_instr_i;
          is_store_d = walk_is_store_i;
          state_d    = WAIT_GRANT;
        end
      end

      WAIT_GRANT: begin
        // request held with a stable address until granted
        mem_req_o = 1'b1;
        if (mem_gnt_i) begin
          state_d = PTE_LOOKUP;
        end
      end

      PTE_LOOKUP: begin
        // verdict stays none until the read data is registered
        case (walk.verdict)
          ptw_pkg::POINTER: begin
            walk.advance = 1'b1;
            state_d      = WAIT_GRANT;
          end
          ptw_pkg::LEAF_OK: begin
            update_valid_o = 1'b1;
            state_d        = LATENCY;
          end
          ptw_pkg::FAULT: begin
            state_d = PROPAGATE_ERROR;
          end
          default: begin
            state_d = PTE_LOOKUP;
          end
        endcase
      end

      PROPAGATE_ERROR: begin
        walk_error_o = 1'b1;
        state_d      = LATENCY;
      end

      // drain of a read granted before a flush
      WAIT_RVALID: begin
        if (walk.verdict != ptw_pkg::NONE) begin
          state_d = IDLE;
        end
      end

      LATENCY: begin
        state_d = IDLE;
      end

      default: begin
        state_d = IDLE;
      end
    endcase

    // -----------------------------------------------------------------------
    // flush
    // -----------------------------------------------------------------------
    // a read already granted must come back before the next walk starts,
    // otherwise its rvalid would be taken as data of the new walk
    if (flush_i) begin
      walk.advance   = 1'b0;
      update_valid_o = 1'b0;
      walk_error_o   = 1'b0;
      if ((state_q == WAIT_GRANT && mem_gnt_i) ||
          ((state_q inside {PTE_LOOKUP, WAIT_RVALID}) &&
           walk.verdict == ptw_pkg::NONE)) begin
        state_d = WAIT_RVALID;
      end else begin
        state_d = IDLE;
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q    <= IDLE;
      is_instr_q <= 1'b0;
      is_store_q <= 1'b0;
    end else begin
      state_q    <= state_d;
      is_instr_q <= is_instr_d;
      is_store_q <= is_store_d;
    end
  end

  // -------------------------------------------------------------------------
  // checks
  // -------------------------------------------------------------------------

  // one outcome per walk
  a_one_outcome: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !(update_valid_o && walk_error_o))
    else $error("update and error pulse together");

  a_req_in_grant: assert property (@(posedge clk_i) disable iff (!rst_ni)
    mem_req_o |-> state_q == WAIT_GRANT)
    else $error("memory request outside of grant wait");

  // address from the context block holds while the port stalls
  a_req_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
    mem_req_o && !mem_gnt_i && !flush_i |=> mem_req_o && $stable(walk.pptr))
    else $error("memory request dropped or address changed before grant");

endmodule

`default_nettype wire

// ==== common/walk_if.sv ====
`timescale 1ns/1ps
`default_nettype none

interface walk_if;

  // start of a new walk, context and global bit restart
  logic load;
  // pointer pte accepted, step one level down
  logic advance;
  // access kind of the walk in flight
  logic is_instr;
  logic is_store;

  // current table level and address of the pte to fetch
  ptw_pkg::ptw_lvl_e level;
  logic [ptw_pkg::plen-1:0] pptr;

  // checker result and the entry handed to the tlb
  ptw_pkg::pte_verdict_e verdict;
  ptw_pkg::pte_t leaf_pte;

  // sequencing side
  modport ctrl (
    output load, advance, is_instr, is_store,
    input  verdict, pptr
  );

  // level and pointer registers
  modport ctx (
    input  load, advance, leaf_pte,
    output level, pptr
  );

  // pte decode
  modport chk (
    input  load, level, is_instr, is_store,
    output verdict, leaf_pte
  );

endinterface

`default_nettype wire

// ==== common/ptw_pkg.sv ====
`default_nettype none

package ptw_pkg;

  // -------------------------------------------------------------------------
  // sv39 geometry
  // -------------------------------------------------------------------------

  // virtual address, sign bits above bit 38 are not carried
  localparam int unsigned vlen = 39;
  // physical address as seen on the memory port
  localparam int unsigned plen = 56;
  // physical page number held in satp and in every pte
  localparam int unsigned ppn_w = 44;
  // one vpn slice indexes 512 entries of a table
  localparam int unsigned vpn_w = 9;
  localparam int unsigned asid_w = 16;
  localparam int unsigned pte_w = 64;
  localparam int unsigned page_offset_w = 12;
  // 8 byte entries, low pointer bits are always zero
  localparam int unsigned pte_size_log2 = 3;

  // -------------------------------------------------------------------------
  // walk state shared between the blocks
  // -------------------------------------------------------------------------

  // lvl1 is the root table and maps 1G pages
  typedef enum logic [1:0] {
    LVL1,
    LVL2,
    LVL3
  } ptw_lvl_e;

  // verdict on the pte currently in the read register
  // none means no read data was registered this cycle
  typedef enum logic [1:0] {
    NONE,
    POINTER,
    LEAF_OK,
    FAULT
  } pte_verdict_e;

  // -------------------------------------------------------------------------
  // page table entry
  // -------------------------------------------------------------------------

  // msb first, matches the privileged spec layout
  typedef struct packed {
    logic [9:0]       reserved;
    logic [ppn_w-1:0] ppn;
    // free for software
    logic [1:0]       rsw;
    logic             d;
    logic             a;
    logic             g;
    logic             u;
    logic             x;
    logic             w;
    logic             r;
    logic             v;
  } pte_t;

  // read word from memory, written raw and decoded as a pte
  typedef union packed {
    logic [pte_w-1:0] raw;
    pte_t             pte;
  } pte_word_u;

endpackage

`default_nettype wire
